//--- rtl/prof_event_pkg.sv
`default_nettype none

package prof_event_pkg;

   //////////////////////////////////////////////////
   // cycle classes

   localparam int CLASS_W     = 3;  // bits per class code
   localparam int NUM_CLASSES = 8;  // class counters per tile

   // one code per cycle and tile
   // decode picks the lowest nonzero code whose stall input is set
   typedef enum logic [CLASS_W-1:0]
   {
      CLS_RUN      = 3'd0,  // no stall seen
      CLS_DMEM     = 3'd1,  // data memory stall
      CLS_DX       = 3'd2,  // dependency stall
      CLS_BT       = 3'd3,  // branch flush
      CLS_IN_FULL  = 3'd4,  // incoming fifo full
      CLS_OUT_FULL = 3'd5,  // outgoing fifo full
      CLS_CREDIT   = 3'd6,  // out of credits
      CLS_RES_ACQ  = 3'd7   // waiting on resource acquire
   } stall_class_e;

   // the counter bank keeps one counter for each code above, so the
   // enum has to cover 0 .. NUM_CLASSES-1 with no gaps

endpackage : prof_event_pkg

`default_nettype wire

//--- rtl/prof_readout_pkg.sv
`default_nettype none

package prof_readout_pkg;

   //////////////////////////////////////////////////
   // read port selector

   localparam int SEL_W = 4;

   // codes 0..7 follow the class codes of prof_event_pkg
   typedef enum logic [SEL_W-1:0]
   {
      SEL_RUN      = 4'd0,
      SEL_DMEM     = 4'd1,
      SEL_DX       = 4'd2,
      SEL_BT       = 4'd3,
      SEL_IN_FULL  = 4'd4,
      SEL_OUT_FULL = 4'd5,
      SEL_CREDIT   = 4'd6,
      SEL_RES_ACQ  = 4'd7,
      SEL_TOTAL    = 4'd8,  // total cycles in window
      SEL_STATUS   = 4'd9   // window state word
   } rd_sel_e;

   //////////////////////////////////////////////////
   // status word layout with the other bits at zero

   localparam int STATUS_RUNNING_BIT = 0;  // window open
   localparam int STATUS_DONE_BIT    = 1;  // window closed by finish

endpackage : prof_readout_pkg

`default_nettype wire

//--- rtl/prof_event_decode.sv
`timescale 1ns/1ps
`default_nettype none

module prof_event_decode
   import prof_event_pkg::*;
#(
   parameter int num_tiles_p = 4
)
(
   input  wire logic                   clk,
   input  wire logic                   reset_i,

   input  wire logic [num_tiles_p-1:0] freeze_i,
   input  wire logic                   finish_i,        // global, all tiles

   input  wire logic [num_tiles_p-1:0] dmem_stall_i,
   input  wire logic [num_tiles_p-1:0] dx_stall_i,
   input  wire logic [num_tiles_p-1:0] bt_stall_i,
   input  wire logic [num_tiles_p-1:0] in_fifo_full_i,
   input  wire logic [num_tiles_p-1:0] out_fifo_full_i,
   input  wire logic [num_tiles_p-1:0] credit_full_i,
   input  wire logic [num_tiles_p-1:0] res_acq_stall_i,

   output logic [num_tiles_p-1:0]      start_o,         // unfreeze seen
   output logic [num_tiles_p-1:0]      stop_o,          // finish seen
   output stall_class_e [num_tiles_p-1:0] class_o
);

   logic [num_tiles_p-1:0]       freeze_r;
   logic [num_tiles_p-1:0]       unfreeze;
   stall_class_e [num_tiles_p-1:0] class_n;

   //////////////////////////////////////////////////
   // unfreeze edge

   // freeze_r resets low, so no false edge right after reset
   assign unfreeze = freeze_r & ~freeze_i;

   //////////////////////////////////////////////////
   // fixed priority with dmem highest

   always_comb
   begin
      for (int t = 0; t < num_tiles_p; t++)
      begin
         if (dmem_stall_i[t])
            class_n[t] = CLS_DMEM;
         else if (dx_stall_i[t])
            class_n[t] = CLS_DX;
         else if (bt_stall_i[t])
            class_n[t] = CLS_BT;
         else if (in_fifo_full_i[t])
            class_n[t] = CLS_IN_FULL;
         else if (out_fifo_full_i[t])
            class_n[t] = CLS_OUT_FULL;
         else if (credit_full_i[t])
            class_n[t] = CLS_CREDIT;
         else if (res_acq_stall_i[t])
            class_n[t] = CLS_RES_ACQ;
         else
            class_n[t] = CLS_RUN;  // nothing stalled
      end
   end

   //////////////////////////////////////////////////
   // output stage

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         freeze_r <= '0;
         start_o  <= '0;
         stop_o   <= '0;
      end
      else
      begin
         freeze_r <= freeze_i;
         start_o  <= unfreeze;
         stop_o   <= {num_tiles_p{finish_i}};
      end
   end

   // class of each tile one cycle after its inputs
   always_ff @(posedge clk)
   begin
      class_o <= class_n;
   end

   // finish must never land on a tile's unfreeze cycle, otherwise the
   // window would open and close in the same cycle
   a_start_stop_excl : assert property (@(posedge clk) disable iff (reset_i)
      (start_o & stop_o) == '0)
      else $error("start and stop together on tiles %b", start_o & stop_o);

endmodule : prof_event_decode

`default_nettype wire

//--- rtl/prof_counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module prof_counter_bank
   import prof_event_pkg::*;
#(
   parameter int num_tiles_p     = 4,
   parameter int counter_width_p = 32
)
(
   input  wire logic                   clk,
   input  wire logic                   reset_i,

   input  wire logic [num_tiles_p-1:0] start_i,
   input  wire logic [num_tiles_p-1:0] stop_i,
   input  wire stall_class_e [num_tiles_p-1:0] class_i,

   // tile t, class c at (t*NUM_CLASSES + c)*counter_width_p
   output logic [num_tiles_p*NUM_CLASSES*counter_width_p-1:0] counts_o,
   output logic [num_tiles_p*counter_width_p-1:0]             total_o,
   output logic [num_tiles_p-1:0]                             running_o,
   output logic [num_tiles_p-1:0]                             done_o
);

   //////////////////////////////////////////////////
   // one window and counter set per tile

   for (genvar t = 0; t < num_tiles_p; t++)
   begin : g_tile

      logic                       running_r;
      logic                       done_r;
      logic [counter_width_p-1:0] class_cnt_r [NUM_CLASSES];
      logic [counter_width_p-1:0] total_r;

      // start > stop > count
      always_ff @(posedge clk)
      begin
         if (reset_i)
         begin
            running_r <= 1'b0;
            done_r    <= 1'b0;
            total_r   <= '0;
            for (int c = 0; c < NUM_CLASSES; c++)
            begin
               class_cnt_r[c] <= '0;
            end
         end
         else if (start_i[t])
         begin
            // new window drops old results
            running_r <= 1'b1;
            done_r    <= 1'b0;
            total_r   <= '0;
            for (int c = 0; c < NUM_CLASSES; c++)
            begin
               class_cnt_r[c] <= '0;
            end
         end
         else if (stop_i[t])
         begin
            running_r <= 1'b0;
            done_r    <= 1'b1;
         end
         else if (running_r)
         begin
            // both wrap at counter_width_p
            class_cnt_r[class_i[t]] <= class_cnt_r[class_i[t]] + 1'b1;
            total_r                 <= total_r + 1'b1;
         end
      end

      for (genvar c = 0; c < NUM_CLASSES; c++)
      begin : g_class
         assign counts_o[(t*NUM_CLASSES + c)*counter_width_p +: counter_width_p] =
            class_cnt_r[c];
      end

      assign total_o[t*counter_width_p +: counter_width_p] = total_r;
      assign running_o[t] = running_r;
      assign done_o[t]    = done_r;

   end

   //////////////////////////////////////////////////
   // checks

   // a tile is never counting and finished at once
   a_state_excl : assert property (@(posedge clk) disable iff (reset_i)
      (running_o & done_o) == '0)
      else $error("running and done together on tiles %b", running_o & done_o);

endmodule : prof_counter_bank

`default_nettype wire

//--- rtl/prof_readout.sv
`timescale 1ns/1ps
`default_nettype none

module prof_readout
   import prof_event_pkg::*;
   import prof_readout_pkg::*;
#(
   parameter int num_tiles_p     = 4,
   parameter int counter_width_p = 32,
   localparam int tile_w_lp      = (num_tiles_p > 1) ? $clog2(num_tiles_p) : 1
)
(
   input  wire logic                 clk,
   input  wire logic                 reset_i,

   input  wire logic                 rd_req_i,   // one read per pulse
   input  wire logic [tile_w_lp-1:0] rd_tile_i,
   input  wire rd_sel_e              rd_sel_i,

   input  wire logic [num_tiles_p*NUM_CLASSES*counter_width_p-1:0] counts_i,
   input  wire logic [num_tiles_p*counter_width_p-1:0]             total_i,
   input  wire logic [num_tiles_p-1:0]                             running_i,
   input  wire logic [num_tiles_p-1:0]                             done_i,

   output logic                       rd_valid_o,
   output logic [counter_width_p-1:0] rd_data_o
);

   logic [counter_width_p-1:0] sel_value;

   //////////////////////////////////////////////////
   // read mux

   always_comb
   begin
      sel_value = '0;
      if (rd_sel_i == SEL_STATUS)
      begin
         sel_value[STATUS_RUNNING_BIT] = running_i[rd_tile_i];
         sel_value[STATUS_DONE_BIT]    = done_i[rd_tile_i];
      end
      else if (rd_sel_i == SEL_TOTAL)
         sel_value = total_i[rd_tile_i*counter_width_p +: counter_width_p];
      else if (rd_sel_i < SEL_TOTAL)  // class counter
         sel_value = counts_i[(rd_tile_i*NUM_CLASSES + rd_sel_i[CLASS_W-1:0])
                              *counter_width_p +: counter_width_p];
   end

   // value is the one before the request edge
   always_ff @(posedge clk)
   begin
      if (reset_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_req_i;
   end

   always_ff @(posedge clk)
   begin
      if (rd_req_i)
         rd_data_o <= sel_value;  // held until next request
   end

   a_rd_range : assert property (@(posedge clk) disable iff (reset_i)
      rd_req_i |-> (rd_tile_i < num_tiles_p) && (rd_sel_i <= SEL_STATUS))
      else $error("read out of range, tile %0d sel %0d", rd_tile_i, rd_sel_i);

endmodule : prof_readout

`default_nettype wire

//--- rtl/prof_top.sv
`timescale 1ns/1ps
`default_nettype none

module prof_top
   import prof_event_pkg::*;
   import prof_readout_pkg::*;
#(
   parameter int num_tiles_p     = 4,
   parameter int counter_width_p = 32,
   localparam int tile_w_lp      = (num_tiles_p > 1) ? $clog2(num_tiles_p) : 1
)
(
   input  wire logic                   clk,
   input  wire logic                   reset_i,

   // tile observation with one bit per tile
   input  wire logic [num_tiles_p-1:0] freeze_i,
   input  wire logic [num_tiles_p-1:0] dmem_stall_i,
   input  wire logic [num_tiles_p-1:0] dx_stall_i,
   input  wire logic [num_tiles_p-1:0] bt_stall_i,
   input  wire logic [num_tiles_p-1:0] in_fifo_full_i,
   input  wire logic [num_tiles_p-1:0] out_fifo_full_i,
   input  wire logic [num_tiles_p-1:0] credit_full_i,
   input  wire logic [num_tiles_p-1:0] res_acq_stall_i,
   input  wire logic                   finish_i,

   // read port
   input  wire logic                   rd_req_i,
   input  wire logic [tile_w_lp-1:0]   rd_tile_i,
   input  wire rd_sel_e                rd_sel_i,
   output logic                        rd_valid_o,
   output logic [counter_width_p-1:0]  rd_data_o
);

   logic [num_tiles_p-1:0]         start_lo;
   logic [num_tiles_p-1:0]         stop_lo;
   stall_class_e [num_tiles_p-1:0] class_lo;

   logic [num_tiles_p*NUM_CLASSES*counter_width_p-1:0] counts_lo;
   logic [num_tiles_p*counter_width_p-1:0]             total_lo;
   logic [num_tiles_p-1:0]                             running_lo;
   logic [num_tiles_p-1:0]                             done_lo;

   //////////////////////////////////////////////////
   // decode -> counters -> readout

   prof_event_decode #(
      .num_tiles_p     (num_tiles_p)
   ) u_decode (
      .clk             (clk),
      .reset_i         (reset_i),
      .freeze_i        (freeze_i),
      .finish_i        (finish_i),
      .dmem_stall_i    (dmem_stall_i),
      .dx_stall_i      (dx_stall_i),
      .bt_stall_i      (bt_stall_i),
      .in_fifo_full_i  (in_fifo_full_i),
      .out_fifo_full_i (out_fifo_full_i),
      .credit_full_i   (credit_full_i),
      .res_acq_stall_i (res_acq_stall_i),
      .start_o         (start_lo),
      .stop_o          (stop_lo),
      .class_o         (class_lo)
   );

   prof_counter_bank #(
      .num_tiles_p     (num_tiles_p),
      .counter_width_p (counter_width_p)
   ) u_counters (
      .clk       (clk),
      .reset_i   (reset_i),
      .start_i   (start_lo),
      .stop_i    (stop_lo),
      .class_i   (class_lo),
      .counts_o  (counts_lo),
      .total_o   (total_lo),
      .running_o (running_lo),
      .done_o    (done_lo)
   );

   prof_readout #(
      .num_tiles_p     (num_tiles_p),
      .counter_width_p (counter_width_p)
   ) u_readout (
      .clk        (clk),
      .reset_i    (reset_i),
      .rd_req_i   (rd_req_i),
      .rd_tile_i  (rd_tile_i),
      .rd_sel_i   (rd_sel_i),
      .counts_i   (counts_lo),
      .total_i    (total_lo),
      .running_i  (running_lo),
      .done_i     (done_lo),
      .rd_valid_o (rd_valid_o),
      .rd_data_o  (rd_data_o)
   );

endmodule : prof_top

`default_nettype wire

//--- verification/prof_checker.sv
`timescale 1ns/1ps
`default_nettype none

module prof_checker
   import prof_event_pkg::*;
   import prof_readout_pkg::*;
#(
   parameter int num_tiles_p     = 4,
   parameter int counter_width_p = 32,
   localparam int tile_w_lp      = (num_tiles_p > 1) ? $clog2(num_tiles_p) : 1
)
(
   input  wire logic                       clk,
   input  wire logic                       reset_i,
   input  wire logic [num_tiles_p-1:0]     freeze_i,
   input  wire logic [num_tiles_p-1:0]     dmem_stall_i,
   input  wire logic [num_tiles_p-1:0]     dx_stall_i,
   input  wire logic [num_tiles_p-1:0]     bt_stall_i,
   input  wire logic [num_tiles_p-1:0]     in_fifo_full_i,
   input  wire logic [num_tiles_p-1:0]     out_fifo_full_i,
   input  wire logic [num_tiles_p-1:0]     credit_full_i,
   input  wire logic [num_tiles_p-1:0]     res_acq_stall_i,
   input  wire logic                       finish_i,
   input  wire logic                       rd_req_i,
   input  wire logic [tile_w_lp-1:0]       rd_tile_i,
   input  wire logic [SEL_W-1:0]           rd_sel_i,
   input  wire logic                       rd_valid_i,
   input  wire logic [counter_width_p-1:0] rd_data_i,
   output int                              data_errors_o,
   output int                              valid_errors_o,
   output int                              reads_checked_o
);

   int data_errs  = 0;
   int valid_errs = 0;
   int read_count = 0;

   // decode stage model one edge behind the inputs
   logic [num_tiles_p-1:0] m_freeze_r;
   logic [num_tiles_p-1:0] m_start;
   logic [num_tiles_p-1:0] m_stop;
   logic [CLASS_W-1:0]     m_class [num_tiles_p];

   // model of the counter bank
   logic [num_tiles_p-1:0]     m_running;
   logic [num_tiles_p-1:0]     m_done;
   logic [counter_width_p-1:0] m_counts [num_tiles_p][NUM_CLASSES];
   logic [counter_width_p-1:0] m_total [num_tiles_p];

   logic                       req_q = 1'b0;  // read seen at the last edge
   int                         tile_q;
   int                         sel_q;
   logic [counter_width_p-1:0] exp_data;

   assign data_errors_o   = data_errs;
   assign valid_errors_o  = valid_errs;
   assign reads_checked_o = read_count;

   //////////////////////////////////////////////////
   // reference rules

   // first set bit wins with dmem at bit 0
   function automatic logic [CLASS_W-1:0] classify(input logic [6:0] stalls);
      for (int i = 0; i < 7; i++)
      begin
         if (stalls[i])
            return CLASS_W'(i + 1);
      end
      return CLS_RUN;
   endfunction

   function automatic logic [counter_width_p-1:0] model_value(input int t, input int s);
      logic [counter_width_p-1:0] v;
      v = '0;
      if (s < NUM_CLASSES)
         v = m_counts[t][s];
      else if (s == SEL_TOTAL)
         v = m_total[t];
      else if (s == SEL_STATUS)
      begin
         v[STATUS_RUNNING_BIT] = m_running[t];
         v[STATUS_DONE_BIT]    = m_done[t];
      end
      return v;
   endfunction

   task automatic clear_tile(input int t);
      m_total[t] = '0;
      for (int c = 0; c < NUM_CLASSES; c++)
      begin
         m_counts[t][c] = '0;
      end
   endtask

   //////////////////////////////////////////////////
   // compare at the falling edge before stepping the model

   always @(negedge clk)
   begin
      logic [6:0] stalls;
      if (rd_valid_i !== req_q)
      begin
         valid_errs++;
         $display("FAILED at %0t: rd_valid_o is %b, expected %b", $time, rd_valid_i, req_q);
      end
      if (req_q)
      begin
         read_count++;
         if (rd_data_i !== exp_data)
         begin
            data_errs++;
            $display("FAILED at %0t: tile %0d sel %0d read 0x%0h, expected 0x%0h",
                     $time, tile_q, sel_q, rd_data_i, exp_data);
         end
      end
      // counters as they stand before the coming edge
      req_q = rd_req_i && !reset_i;
      if (rd_req_i)
      begin
         tile_q   = rd_tile_i;
         sel_q    = rd_sel_i;
         exp_data = model_value(tile_q, sel_q);
      end
      if (reset_i)
      begin
         m_freeze_r = '0;
         m_start    = '0;
         m_stop     = '0;
         m_running  = '0;
         m_done     = '0;
         for (int t = 0; t < num_tiles_p; t++)
         begin
            clear_tile(t);
            m_class[t] = CLS_RUN;
         end
      end
      else
      begin
         for (int t = 0; t < num_tiles_p; t++)
         begin
            if (m_start[t])
            begin
               m_running[t] = 1'b1;
               m_done[t]    = 1'b0;
               clear_tile(t);
            end
            else if (m_stop[t])
            begin
               m_running[t] = 1'b0;
               m_done[t]    = 1'b1;
            end
            else if (m_running[t])
            begin
               m_counts[t][m_class[t]] = m_counts[t][m_class[t]] + 1'b1;
               m_total[t]              = m_total[t] + 1'b1;
            end
            stalls = {res_acq_stall_i[t], credit_full_i[t], out_fifo_full_i[t],
                      in_fifo_full_i[t], bt_stall_i[t], dx_stall_i[t], dmem_stall_i[t]};
            m_class[t] = classify(stalls);
            m_start[t] = m_freeze_r[t] & ~freeze_i[t];  // falling freeze
            m_stop[t]  = finish_i;
         end
         m_freeze_r = freeze_i;
      end
   end

endmodule : prof_checker

`default_nettype wire

//--- verification/tb_prof_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_prof_top
   import prof_readout_pkg::*;
();

   localparam int num_tiles_lp  = 4;
   localparam int period_lp     = 100;
   localparam int num_phases_lp = 11;
   localparam int margin_lp     = 20;
   localparam int sels_lp       = SEL_STATUS + 1;

   typedef struct packed
   {
      logic [15:0]     len;       // cycles in the phase
      logic [3:0]      freeze;
      logic [6:0][3:0] stall;     // [input][tile] with dmem as input 0
      logic            rnd;       // add lcg stalls on top
      logic            finish;
      logic [3:0]      rd_tiles;  // tiles read back afterwards
   } phase_t;

   // stall nibbles from res_acq down to dmem
   localparam phase_t phases [num_phases_lp] = '{
      '{16'd6,  4'hf, 28'hfffffff, 1'b0, 1'b0, 4'hf},  // frozen so nothing counts
      '{16'd1,  4'he, 28'h0100110, 1'b0, 1'b0, 4'h0},  // tile 0 unfreezes
      '{16'd3,  4'hc, 28'h0100110, 1'b0, 1'b0, 4'h0},  // tile 1 unfreezes and dx wins on tile 0
      '{16'd5,  4'h0, 28'h0f00ff8, 1'b0, 1'b0, 4'h0},  // tiles 2 and 3
      '{16'd4,  4'h0, 28'hf060000, 1'b0, 1'b0, 4'h0},
      '{16'd1,  4'h0, 28'h0000000, 1'b0, 1'b1, 4'hf},  // finish with staggered totals
      '{16'd1,  4'h1, 28'h0000000, 1'b0, 1'b0, 4'h0},
      '{16'd3,  4'h0, 28'h0001000, 1'b0, 1'b0, 4'h1},  // second window clears tile 0
      '{16'd1,  4'hf, 28'h0000000, 1'b0, 1'b0, 4'h0},
      '{16'd40, 4'h0, 28'h0000000, 1'b1, 1'b0, 4'h0},  // random stalls
      '{16'd1,  4'h0, 28'h0000000, 1'b0, 1'b1, 4'hf}
   };

   logic            clk = 1'b0;
   logic            reset;
   logic [3:0]      freeze;
   logic [6:0][3:0] stall;
   logic            finish;
   logic            rd_req;
   logic [1:0]      rd_tile;
   rd_sel_e         rd_sel;
   logic            rd_valid;
   logic [31:0]     rd_data;
   logic [31:0]     lcg_state = 32'ha625ac32;
   int              data_errors;
   int              valid_errors;
   int              reads_checked;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int expected_reads();
      int n;
      n = 0;
      for (int r = 0; r < num_phases_lp; r++)
      begin
         n += sels_lp * $countones(phases[r].rd_tiles);
      end
      return n;
   endfunction

   function automatic int total_cycles();
      int n;
      n = expected_reads() + 2;  // two cycles of tail
      for (int r = 0; r < num_phases_lp; r++)
      begin
         n += int'(phases[r].len);
      end
      return n;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;  // inputs move just after the edge
   endtask

   task automatic read_tile(input int t);
      for (int s = 0; s < sels_lp; s++)
      begin
         rd_req  = 1'b1;
         rd_tile = 2'(t);
         rd_sel  = rd_sel_e'(s);
         step();
      end
      rd_req = 1'b0;
   endtask

   task automatic run_phase(input phase_t p);
      logic [31:0] r1;
      logic [31:0] r2;
      for (int c = 0; c < int'(p.len); c++)
      begin
         freeze = p.freeze;
         finish = p.finish;
         stall  = p.stall;
         if (p.rnd)
         begin
            for (int i = 0; i < 7; i++)
            begin
               lcg_state = lcg_next(lcg_state);
               r1        = lcg_state;
               lcg_state = lcg_next(lcg_state);
               r2        = lcg_state;
               stall[i]  = stall[i] | (r1[31:28] & r2[31:28]);  // about one in four
            end
         end
         step();
      end
      finish = 1'b0;
      stall  = '0;
      for (int t = 0; t < num_tiles_lp; t++)
      begin
         if (p.rd_tiles[t])
            read_tile(t);
      end
   endtask

   //////////////////////////////////////////////////
   // clock, DUT and checker

   initial
   begin
      forever #(period_lp/2) clk = ~clk;
   end

   prof_top #(
      .num_tiles_p     (num_tiles_lp),
      .counter_width_p (32)
   ) u_dut (
      .clk             (clk),
      .reset_i         (reset),
      .freeze_i        (freeze),
      .dmem_stall_i    (stall[0]),
      .dx_stall_i      (stall[1]),
      .bt_stall_i      (stall[2]),
      .in_fifo_full_i  (stall[3]),
      .out_fifo_full_i (stall[4]),
      .credit_full_i   (stall[5]),
      .res_acq_stall_i (stall[6]),
      .finish_i        (finish),
      .rd_req_i        (rd_req),
      .rd_tile_i       (rd_tile),
      .rd_sel_i        (rd_sel),
      .rd_valid_o      (rd_valid),
      .rd_data_o       (rd_data)
   );

   prof_checker #(
      .num_tiles_p     (num_tiles_lp),
      .counter_width_p (32)
   ) u_checker (
      .clk             (clk),
      .reset_i         (reset),
      .freeze_i        (freeze),
      .dmem_stall_i    (stall[0]),
      .dx_stall_i      (stall[1]),
      .bt_stall_i      (stall[2]),
      .in_fifo_full_i  (stall[3]),
      .out_fifo_full_i (stall[4]),
      .credit_full_i   (stall[5]),
      .res_acq_stall_i (stall[6]),
      .finish_i        (finish),
      .rd_req_i        (rd_req),
      .rd_tile_i       (rd_tile),
      .rd_sel_i        (rd_sel),
      .rd_valid_i      (rd_valid),
      .rd_data_i       (rd_data),
      .data_errors_o   (data_errors),
      .valid_errors_o  (valid_errors),
      .reads_checked_o (reads_checked)
   );

   //////////////////////////////////////////////////
   // stimulus

   initial
   begin
      reset   = 1'b1;
      freeze  = 4'hf;  // tiles start frozen
      stall   = '0;
      finish  = 1'b0;
      rd_req  = 1'b0;
      rd_tile = '0;
      rd_sel  = SEL_RUN;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int r = 0; r < num_phases_lp; r++)
      begin
         run_phase(phases[r]);
      end
      step();
      step();  // last read compared
      $display("checker: %0d reads compared, %0d data errors, %0d valid errors",
               reads_checked, data_errors, valid_errors);
      if (reads_checked != expected_reads())
         $display("only %0d of %0d reads were compared", reads_checked, expected_reads());
      if (data_errors == 0 && valid_errors == 0 && reads_checked == expected_reads())
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog
   initial
   begin
      int limit;
      limit = 4 + total_cycles() + margin_lp;
      repeat (limit) @(posedge clk);
      $display("watchdog: stimulus still running after %0d cycles, run stopped", limit);
      $display("*** FAILED ***");
      $finish;
   end

endmodule : tb_prof_top

`default_nettype wire

//--- list.f
rtl/prof_event_pkg.sv
rtl/prof_readout_pkg.sv
rtl/prof_event_decode.sv
rtl/prof_counter_bank.sv
rtl/prof_readout.sv
rtl/prof_top.sv
verification/prof_checker.sv
verification/tb_prof_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_prof_top
FILELIST  = list.f

.PHONY: sim clean

# builds and runs, fails unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
